//--- vlog.f
secv_pkg.sv
funit_if.sv
secv_gpr.sv
secv_decoder.sv
secv_alu.sv
secv_lsu.sv
secv.sv
secv_props.sv
tb_secv.sv

//--- tb_secv.sv
// Testbench for the secv core with bus memory models, program loader, ISS reference, monitor and tests
`timescale 1ns/100ps

module tb_secv;

    logic                            clk_i = 1'b0;
    logic                            rst_i;
    logic                            imem_cyc_o;
    logic                            imem_stb_o;
    logic [secv_pkg::IADR_WIDTH-1:0] imem_adr_o;
    logic [secv_pkg::ILEN-1:0]       imem_dat_i;
    logic                            imem_ack_i;
    logic                            dmem_cyc_o;
    logic                            dmem_stb_o;
    logic [secv_pkg::DADR_WIDTH-1:0] dmem_adr_o;
    logic                            dmem_we_o;
    logic [secv_pkg::XLEN-1:0]       dmem_dat_o;
    logic [secv_pkg::XLEN-1:0]       dmem_dat_i;
    logic                            dmem_ack_i;
    logic                            illegal_o;

    // Bus memories and the model's own data image
    logic [31:0] imem [1024];
    logic [31:0] dmem [1024];
    logic [31:0] model_mem [1024];
    // Store log entries are {word address, data}
    logic [41:0] exp_st[$];
    logic [41:0] got_st[$];
    logic [31:0] exp_ill[$];
    logic [31:0] got_ill[$];
    int          seed;
    int          idly;
    int          ddly;
    int          plen;
    int          errors;
    int          passed;
    int          failed;

    secv i_dut (.*);

    initial begin
        forever #10 clk_i = ~clk_i;
    end

    // Both memories answer after 0 to 3 extra cycles
    always @(negedge clk_i) begin
        if (imem_cyc_o && !imem_ack_i) begin
            if (idly == 0) begin
                imem_ack_i = 1'b1;
                imem_dat_i = imem[imem_adr_o];
            end else begin
                idly--;
            end
        end else begin
            imem_ack_i = 1'b0;
            idly = $random(seed) & 3;
        end
        if (dmem_cyc_o && !dmem_ack_i) begin
            if (ddly == 0) begin
                dmem_ack_i = 1'b1;
                dmem_dat_i = dmem[dmem_adr_o];
                if (dmem_we_o) begin
                    dmem[dmem_adr_o] = dmem_dat_o;
                end
            end else begin
                ddly--;
            end
        end else begin
            dmem_ack_i = 1'b0;
            ddly = $random(seed) & 3;
        end
    end

    // Monitor logs acknowledged writes and each illegal pulse with its instruction PC
    always @(posedge clk_i) begin
        if (!rst_i && dmem_cyc_o && dmem_ack_i && dmem_we_o) begin
            got_st.push_back({dmem_adr_o, dmem_dat_o});
        end
        if (!rst_i && illegal_o) begin
            got_ill.push_back({20'b0, imem_adr_o, 2'b00});
        end
    end

    // Instruction encoders
    function automatic logic [31:0] alu_rr(input logic [9:0] f73, input int rd, rs1, rs2);
        return {f73[9:3], rs2[4:0], rs1[4:0], f73[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] imm_inst(input logic [6:0] opc, input logic [2:0] f3,
                                             input int rd, rs1, imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] store_inst(input int rs2, rs1, imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] branch_inst(input logic [2:0] f3, input int rs1, rs2, imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] lui_inst(input int rd, imm20);
        return {imm20[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] jal_inst(input int rd, imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6F};
    endfunction

    task automatic put_word(input logic [31:0] w);
        imem[plen] = w;
        plen++;
    endtask

    // ISA reference model that runs up to the first jump to itself and returns its PC
    function automatic logic [31:0] iss_run();
        logic [31:0] x [32];
        logic [31:0] pc, npc, inst, a, b, val, ea;
        logic [31:0] immi, imms, immb, immj;
        logic        wr, ill;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc = '0;
        for (int step = 0; step < 4000; step++) begin
            inst = imem[pc[11:2]];
            if (inst[6:0] == 7'h6F && inst[31:12] == '0) begin
                break;
            end
            a    = x[inst[19:15]];
            b    = x[inst[24:20]];
            immi = {{20{inst[31]}}, inst[31:20]};
            imms = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            immb = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            immj = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            npc  = pc + 4;
            wr   = 1'b0;
            ill  = 1'b0;
            val  = '0;
            case (inst[6:0])
                7'h33: begin
                    wr = 1'b1;
                    case ({inst[31:25], inst[14:12]})
                        10'h000: val = a + b;
                        10'h100: val = a - b;
                        10'h007: val = a & b;
                        10'h006: val = a | b;
                        10'h004: val = a ^ b;
                        10'h002: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ill = 1'b1;
                    endcase
                end
                7'h13: begin
                    ill = (inst[14:12] != 3'd0);
                    wr  = 1'b1;
                    val = a + immi;
                end
                7'h37: begin
                    wr  = 1'b1;
                    val = {inst[31:12], 12'b0};
                end
                // Misaligned word access leaves memory and rd alone
                7'h03: begin
                    ill = (inst[14:12] != 3'd2);
                    ea  = a + immi;
                    wr  = (ea[1:0] == 2'b00);
                    val = model_mem[ea[11:2]];
                end
                7'h23: begin
                    ill = (inst[14:12] != 3'd2);
                    ea  = a + imms;
                    if (!ill && ea[1:0] == 2'b00) begin
                        model_mem[ea[11:2]] = b;
                        exp_st.push_back({ea[11:2], b});
                    end
                end
                7'h63: begin
                    ill = (inst[14:13] != 2'b00);
                    if (!ill && ((a == b) != inst[12])) begin
                        npc = pc + immb;
                    end
                end
                7'h6F: begin
                    wr  = 1'b1;
                    val = pc + 4;
                    npc = pc + immj;
                end
                default: ill = 1'b1;
            endcase
            if (ill) begin
                exp_ill.push_back(pc);
                wr  = 1'b0;
                npc = pc + 4;
            end
            if (wr && inst[11:7] != 5'd0) begin
                x[inst[11:7]] = val;
            end
            pc = npc;
        end
        return pc;
    endfunction

    task automatic check(input string sig, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("error: t=%0t %s expected %h got %h", $time, sig, exp, act);
        end
    endtask

    task automatic compare_logs();
        check("store count", exp_st.size(), got_st.size());
        for (int i = 0; i < exp_st.size() && i < got_st.size(); i++) begin
            check("dmem_adr_o", exp_st[i][41:32], got_st[i][41:32]);
            check("dmem_dat_o", exp_st[i][31:0], got_st[i][31:0]);
        end
        check("illegal_o count", exp_ill.size(), got_ill.size());
        for (int i = 0; i < exp_ill.size() && i < got_ill.size(); i++) begin
            check("illegal_o pc", exp_ill[i], got_ill[i]);
        end
    endtask

    // Reset, run the loaded program to its halt word and compare with the model
    task automatic run_program(input string name);
        logic [31:0] halt_pc;
        int          cycles;
        int          errs0;
        logic        done;
        errs0 = errors;
        @(negedge clk_i);
        rst_i = 1'b1;
        for (int i = 0; i < 1024; i++) begin
            dmem[i]      = 32'h5A00_0000 ^ (i * 32'h0001_0203);
            model_mem[i] = dmem[i];
        end
        exp_st.delete();
        exp_ill.delete();
        halt_pc = iss_run();
        repeat (3) @(negedge clk_i);
        got_st.delete();
        got_ill.delete();
        rst_i  = 1'b0;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < 5000) begin
            @(posedge clk_i);
            done = imem_cyc_o && imem_ack_i && (imem_adr_o == halt_pc[11:2]);
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("test %s: core hung, halt address %h was never fetched", name, halt_pc);
        end else begin
            compare_logs();
        end
        if (errors == errs0) begin
            passed++;
            $display("test %s: passed", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - errs0);
        end
    endtask

    task automatic arith_prog();
        plen = 0;
        put_word(imm_inst(7'h13, 0, 1, 0, -5));
        put_word(lui_inst(2, 20'h80001));
        put_word(imm_inst(7'h13, 0, 2, 2, 12'h7FF));
        put_word(imm_inst(7'h13, 0, 10, 0, 12'h100));
        put_word(alu_rr(10'h000, 3, 1, 2));
        put_word(store_inst(3, 10, 0));
        put_word(alu_rr(10'h100, 3, 1, 2));
        put_word(store_inst(3, 10, 4));
        put_word(alu_rr(10'h007, 3, 1, 2));
        put_word(store_inst(3, 10, 8));
        put_word(alu_rr(10'h006, 3, 1, 2));
        put_word(store_inst(3, 10, 12));
        put_word(alu_rr(10'h004, 3, 1, 2));
        put_word(store_inst(3, 10, 16));
        put_word(alu_rr(10'h002, 3, 1, 2));
        put_word(store_inst(3, 10, 20));
        put_word(alu_rr(10'h002, 3, 2, 1));
        put_word(store_inst(3, 10, 24));
        put_word(store_inst(2, 10, 28));
        put_word(jal_inst(0, 0));
        run_program("arith");
    endtask

    // The word at byte offset 12 is never written and returns its fill value
    task automatic mem_prog();
        plen = 0;
        put_word(imm_inst(7'h13, 0, 10, 0, 12'h200));
        put_word(lui_inst(1, 20'hDEADB));
        put_word(imm_inst(7'h13, 0, 1, 1, -273));
        put_word(store_inst(1, 10, 0));
        put_word(imm_inst(7'h13, 0, 2, 0, 12'h055));
        put_word(store_inst(2, 10, 8));
        put_word(imm_inst(7'h03, 2, 3, 10, 0));
        put_word(imm_inst(7'h03, 2, 4, 10, 8));
        put_word(imm_inst(7'h03, 2, 5, 10, 12));
        put_word(store_inst(3, 10, 64));
        put_word(store_inst(4, 10, 68));
        put_word(store_inst(5, 10, 72));
        put_word(jal_inst(0, 0));
        run_program("load store");
    endtask

    task automatic branch_prog();
        plen = 0;
        put_word(imm_inst(7'h13, 0, 10, 0, 12'h300));
        put_word(imm_inst(7'h13, 0, 1, 0, 3));
        // Countdown loop body at byte 8
        put_word(store_inst(1, 10, 0));
        put_word(imm_inst(7'h13, 0, 10, 10, 4));
        put_word(imm_inst(7'h13, 0, 1, 1, -1));
        put_word(branch_inst(3'b001, 1, 0, -12));
        put_word(imm_inst(7'h13, 0, 2, 0, 1));
        put_word(branch_inst(3'b000, 1, 2, 8));
        put_word(store_inst(2, 10, 0));
        put_word(branch_inst(3'b000, 1, 0, 8));
        put_word(store_inst(2, 10, 4));
        put_word(jal_inst(5, 8));
        put_word(store_inst(2, 10, 8));
        put_word(store_inst(5, 10, 12));
        put_word(jal_inst(0, 0));
        run_program("branch jump");
    endtask

    task automatic illegal_prog();
        plen = 0;
        put_word(imm_inst(7'h13, 0, 1, 0, 7));
        put_word(32'hFFFF_FFFF);
        put_word(imm_inst(7'h13, 0, 1, 1, 1));
        // SLLI is outside the subset
        put_word(imm_inst(7'h13, 1, 1, 1, 2));
        put_word(store_inst(1, 0, 0));
        put_word(jal_inst(0, 0));
        run_program("illegal");
    endtask

    task automatic misalign_prog();
        plen = 0;
        put_word(imm_inst(7'h13, 0, 10, 0, 12'h100));
        put_word(imm_inst(7'h13, 0, 1, 0, 12'h077));
        put_word(store_inst(1, 10, 2));
        put_word(imm_inst(7'h13, 0, 3, 0, 9));
        put_word(imm_inst(7'h03, 2, 3, 10, 1));
        put_word(store_inst(3, 10, 0));
        put_word(jal_inst(0, 0));
        run_program("misaligned");
    endtask

    task automatic zero_reg_prog();
        plen = 0;
        put_word(imm_inst(7'h13, 0, 0, 0, 5));
        put_word(lui_inst(0, 20'h12345));
        put_word(imm_inst(7'h13, 0, 1, 0, 3));
        put_word(alu_rr(10'h000, 0, 1, 1));
        put_word(imm_inst(7'h03, 2, 0, 0, 0));
        put_word(store_inst(0, 0, 12'h040));
        put_word(jal_inst(0, 0));
        run_program("x0");
    endtask

    initial begin
        rst_i      = 1'b1;
        imem_ack_i = 1'b0;
        imem_dat_i = '0;
        dmem_ack_i = 1'b0;
        dmem_dat_i = '0;
        seed       = 36;
        idly       = 0;
        ddly       = 0;
        errors     = 0;
        passed     = 0;
        failed     = 0;
        arith_prog();
        mem_prog();
        branch_prog();
        illegal_prog();
        misalign_prog();
        zero_reg_prog();
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 passed, failed, i_dut.i_props.n_fail);
        if (failed == 0 && i_dut.i_props.n_fail == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- secv_props.sv
// Bus protocol and control-state assertions for the secv core, bound into every secv instance
`timescale 1ns/100ps

module secv_props (
    input logic                            clk_i,
    input logic                            rst_i,
    input logic                            imem_cyc_o,
    input logic                            imem_stb_o,
    input logic [secv_pkg::IADR_WIDTH-1:0] imem_adr_o,
    input logic                            imem_ack_i,
    input logic                            dmem_cyc_o,
    input logic                            dmem_stb_o,
    input logic [secv_pkg::DADR_WIDTH-1:0] dmem_adr_o,
    input logic                            dmem_we_o,
    input logic                            dmem_ack_i,
    input logic                            illegal_o
);

    // Failure count, read by the testbench at the end of the run
    int n_fail = 0;

    // Single-request masters, cyc and stb move together
    a_cyc_stb: assert property (@(posedge clk_i) disable iff (rst_i)
        (imem_cyc_o == imem_stb_o) && (dmem_cyc_o == dmem_stb_o))
        else begin
            n_fail++;
            $error("cyc and stb differ on a bus");
        end

    // Pending fetch keeps its address
    a_imem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (imem_cyc_o && !imem_ack_i) |=> (imem_cyc_o && $stable(imem_adr_o)))
        else begin
            n_fail++;
            $error("instruction request changed before ack");
        end

    // Pending data access keeps address and direction
    a_dmem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        (dmem_cyc_o && !dmem_ack_i) |=> (dmem_cyc_o && $stable(dmem_adr_o) && $stable(dmem_we_o)))
        else begin
            n_fail++;
            $error("data request changed before ack");
        end

    // First cycle out of reset is the quiet IDLE cycle
    a_reset_quiet: assert property (@(posedge clk_i)
        $fell(rst_i) |-> !(imem_cyc_o || imem_stb_o || dmem_cyc_o || dmem_stb_o || illegal_o))
        else begin
            n_fail++;
            $error("bus or illegal flag active right after reset");
        end

    a_illegal_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        illegal_o |=> !illegal_o)
        else begin
            n_fail++;
            $error("illegal flag held for two cycles");
        end

endmodule

bind secv secv_props i_props (.*);

//--- secv.sv
// Core top level with main FSM, PC and IR, operand and writeback muxes, branch decision
`timescale 1ns/100ps

module secv (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Instruction bus
    output logic                            imem_cyc_o,
    output logic                            imem_stb_o,
    output logic [secv_pkg::IADR_WIDTH-1:0] imem_adr_o,
    input  logic [secv_pkg::ILEN-1:0]       imem_dat_i,
    input  logic                            imem_ack_i,
    // Data bus
    output logic                            dmem_cyc_o,
    output logic                            dmem_stb_o,
    output logic [secv_pkg::DADR_WIDTH-1:0] dmem_adr_o,
    output logic                            dmem_we_o,
    output logic [secv_pkg::XLEN-1:0]       dmem_dat_o,
    input  logic [secv_pkg::XLEN-1:0]       dmem_dat_i,
    input  logic                            dmem_ack_i,
    // One-cycle pulse per retired illegal encoding
    output logic                            illegal_o
);

    secv_pkg::state_t          state;
    logic [secv_pkg::XLEN-1:0] pc, pc_next, nxtpc, target;
    logic [secv_pkg::ILEN-1:0] ir;
    secv_pkg::dec_t            dec;
    logic [secv_pkg::XLEN-1:0] rs1_dat, rs2_dat, rd_dat, src1, src2;
    logic                      rd_wb, brn_take;
    // Selected unit response and its captured copy
    logic                      fu_rdy, fu_err, fu_err_q;
    logic [secv_pkg::XLEN-1:0] fu_res, fu_res_q;

    funit_if alu_fu ();
    funit_if lsu_fu ();

    secv_gpr i_gpr (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rs1_adr_i (dec.rs1_adr),
        .rs2_adr_i (dec.rs2_adr),
        .rd_adr_i  (dec.rd_adr),
        .rd_dat_i  (rd_dat),
        .rd_wb_i   (rd_wb),
        .rs1_dat_o (rs1_dat),
        .rs2_dat_o (rs2_dat)
    );

    secv_decoder i_decoder (
        .inst_i (ir),
        .dec_o  (dec)
    );

    secv_alu i_alu (
        .fu_i (alu_fu)
    );

    secv_lsu i_lsu (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .fu_i       (lsu_fu),
        .dmem_cyc_o (dmem_cyc_o),
        .dmem_stb_o (dmem_stb_o),
        .dmem_adr_o (dmem_adr_o),
        .dmem_we_o  (dmem_we_o),
        .dmem_dat_o (dmem_dat_o),
        .dmem_dat_i (dmem_dat_i),
        .dmem_ack_i (dmem_ack_i)
    );

    // Memory ops get the effective address on src1
    assign src1 = (dec.funit == secv_pkg::FUNIT_LSU) ? rs1_dat + dec.imm : rs1_dat;
    assign src2 = (dec.src2_sel == secv_pkg::SRC2_SEL_IMM) ? dec.imm : rs2_dat;

    // Both units see the same operands, only one gets ena
    assign alu_fu.ena  = (state == secv_pkg::STATE_EXECUTE) && (dec.funit == secv_pkg::FUNIT_ALU);
    assign alu_fu.op   = dec.funit_op;
    assign alu_fu.src1 = src1;
    assign alu_fu.src2 = src2;
    assign alu_fu.wdat = rs2_dat;
    assign lsu_fu.ena  = (state == secv_pkg::STATE_EXECUTE) && (dec.funit == secv_pkg::FUNIT_LSU);
    assign lsu_fu.op   = dec.funit_op;
    assign lsu_fu.src1 = src1;
    assign lsu_fu.src2 = src2;
    assign lsu_fu.wdat = rs2_dat;

    // Response of the selected unit, no unit means done at once
    always_comb begin
        unique case (dec.funit)
            secv_pkg::FUNIT_ALU: {fu_rdy, fu_err, fu_res} = {alu_fu.rdy, alu_fu.err, alu_fu.res};
            secv_pkg::FUNIT_LSU: {fu_rdy, fu_err, fu_res} = {lsu_fu.rdy, lsu_fu.err, lsu_fu.res};
            default:             {fu_rdy, fu_err, fu_res} = {1'b1, 1'b0, {secv_pkg::XLEN{1'b0}}};
        endcase
    end

    // Branch on equality, BNE inverts
    assign nxtpc    = pc + 32'd4;
    assign target   = pc + dec.imm;
    assign brn_take = (rs1_dat == rs2_dat) ^ dec.bne;

    always_comb begin
        unique case (dec.pc_sel)
            secv_pkg::PC_SEL_BRANCH: pc_next = brn_take ? target : nxtpc;
            secv_pkg::PC_SEL_JUMP:   pc_next = target;
            default:                 pc_next = nxtpc;
        endcase
    end

    // Writeback value and enable, unit errors suppress the write
    always_comb begin
        rd_dat = '0;
        rd_wb  = 1'b0;
        unique case (dec.rd_sel)
            secv_pkg::RD_SEL_FUNIT: {rd_wb, rd_dat} = {!fu_err_q, fu_res_q};
            secv_pkg::RD_SEL_IMM:   {rd_wb, rd_dat} = {1'b1, dec.imm};
            secv_pkg::RD_SEL_NXTPC: {rd_wb, rd_dat} = {1'b1, nxtpc};
            default:                {rd_wb, rd_dat} = {1'b0, {secv_pkg::XLEN{1'b0}}};
        endcase
        if (state != secv_pkg::STATE_WB) begin
            rd_wb = 1'b0;
        end
    end

    // Main FSM
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= secv_pkg::STATE_IDLE;
            pc    <= '0;
            ir    <= secv_pkg::INST_NOP;
        end else begin
            unique case (state)
                secv_pkg::STATE_IDLE:    state <= secv_pkg::STATE_FETCH;
                secv_pkg::STATE_FETCH: begin
                    if (imem_ack_i) begin
                        ir    <= imem_dat_i;
                        state <= secv_pkg::STATE_DECODE;
                    end
                end
                secv_pkg::STATE_DECODE:  state <= secv_pkg::STATE_EXECUTE;
                secv_pkg::STATE_EXECUTE: if (fu_rdy) state <= secv_pkg::STATE_WB;
                secv_pkg::STATE_WB: begin
                    pc    <= pc_next;
                    state <= secv_pkg::STATE_FETCH;
                end
                default:                 state <= secv_pkg::STATE_IDLE;
            endcase
        end
    end

    // Unit response captured at rdy for WB
    always_ff @(posedge clk_i) begin
        if ((state == secv_pkg::STATE_EXECUTE) && fu_rdy) begin
            fu_res_q <= fu_res;
            fu_err_q <= fu_err;
        end
    end

    // Instruction fetch, word address from PC
    assign imem_cyc_o = (state == secv_pkg::STATE_FETCH);
    assign imem_stb_o = (state == secv_pkg::STATE_FETCH);
    assign imem_adr_o = pc[secv_pkg::IADR_WIDTH+1:2];

    assign illegal_o = (state == secv_pkg::STATE_WB) && dec.illegal;

endmodule

//--- secv_lsu.sv
// Load/store function unit with Wishbone data master and word alignment check
`timescale 1ns/100ps

module secv_lsu (
    input  logic                            clk_i,
    input  logic                            rst_i,
    funit_if.unit                           fu_i,
    output logic                            dmem_cyc_o,
    output logic                            dmem_stb_o,
    output logic [secv_pkg::DADR_WIDTH-1:0] dmem_adr_o,
    output logic                            dmem_we_o,
    output logic [secv_pkg::XLEN-1:0]       dmem_dat_o,
    input  logic [secv_pkg::XLEN-1:0]       dmem_dat_i,
    input  logic                            dmem_ack_i
);

    typedef enum logic [1:0] {LSU_IDLE, LSU_BUS, LSU_ERR, LSU_DONE} lsu_state_t;

    lsu_state_t state, state_next;
    logic       aligned;

    // Byte address must be on a word boundary
    assign aligned = (fu_i.src1[1:0] == 2'b00);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= LSU_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            LSU_IDLE: if (fu_i.ena) state_next = aligned ? LSU_BUS : LSU_ERR;
            // Hold the cycle until ack
            LSU_BUS:  if (dmem_ack_i) state_next = LSU_DONE;
            LSU_ERR:  state_next = LSU_DONE;
            // Wait for the core to release ena
            LSU_DONE: if (!fu_i.ena) state_next = LSU_IDLE;
            default:  state_next = LSU_IDLE;
        endcase
    end

    // Wishbone master, request held by stable operands
    assign dmem_cyc_o = (state == LSU_BUS);
    assign dmem_stb_o = (state == LSU_BUS);
    assign dmem_we_o  = (state == LSU_BUS) && (fu_i.op == secv_pkg::FUNIT_OP_STORE);
    assign dmem_adr_o = fu_i.src1[secv_pkg::DADR_WIDTH+1:2];
    assign dmem_dat_o = fu_i.wdat;

    // Load data sampled by the core in the ack cycle
    assign fu_i.res = dmem_dat_i;
    assign fu_i.rdy = ((state == LSU_BUS) && dmem_ack_i) || (state == LSU_ERR);
    assign fu_i.err = (state == LSU_ERR);

endmodule

//--- secv_alu.sv
// Arithmetic-logic function unit, single-cycle answer
`timescale 1ns/100ps

module secv_alu (
    funit_if.unit fu_i
);

    logic slt;

    // Signed compare for SLT
    assign slt = $signed(fu_i.src1) < $signed(fu_i.src2);

    always_comb begin
        unique case (fu_i.op)
            secv_pkg::FUNIT_OP_ADD: fu_i.res = fu_i.src1 + fu_i.src2;
            secv_pkg::FUNIT_OP_SUB: fu_i.res = fu_i.src1 - fu_i.src2;
            secv_pkg::FUNIT_OP_AND: fu_i.res = fu_i.src1 & fu_i.src2;
            secv_pkg::FUNIT_OP_OR:  fu_i.res = fu_i.src1 | fu_i.src2;
            secv_pkg::FUNIT_OP_XOR: fu_i.res = fu_i.src1 ^ fu_i.src2;
            secv_pkg::FUNIT_OP_SLT: fu_i.res = {{(secv_pkg::XLEN-1){1'b0}}, slt};
            // Memory ops never reach the ALU
            default:                fu_i.res = '0;
        endcase
    end

    // Result ready together with ena
    assign fu_i.rdy = fu_i.ena;
    assign fu_i.err = 1'b0;

endmodule

//--- secv_decoder.sv
// Combinational RV32I-subset decoder with immediate generation and illegal flag
`timescale 1ns/100ps

module secv_decoder (
    input  logic [secv_pkg::ILEN-1:0] inst_i,
    output secv_pkg::dec_t            dec_o
);

    secv_pkg::opcode_t         opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [secv_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = secv_pkg::opcode_t'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // Sign-extended immediates per format
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        // Register fields are always at the same place
        dec_o.rs1_adr  = inst_i[19:15];
        dec_o.rs2_adr  = inst_i[24:20];
        dec_o.rd_adr   = inst_i[11:7];
        // Safe no-op defaults
        dec_o.funit    = secv_pkg::FUNIT_NONE;
        dec_o.funit_op = secv_pkg::FUNIT_OP_ADD;
        dec_o.src2_sel = secv_pkg::SRC2_SEL_RS2;
        dec_o.rd_sel   = secv_pkg::RD_SEL_NONE;
        dec_o.pc_sel   = secv_pkg::PC_SEL_NXTPC;
        dec_o.bne      = 1'b0;
        dec_o.imm      = '0;
        dec_o.illegal  = 1'b0;

        unique case (opcode)
            secv_pkg::OPC_OP: begin
                dec_o.funit  = secv_pkg::FUNIT_ALU;
                dec_o.rd_sel = secv_pkg::RD_SEL_FUNIT;
                unique case ({funct7, funct3})
                    10'b0000000_000: dec_o.funit_op = secv_pkg::FUNIT_OP_ADD;
                    10'b0100000_000: dec_o.funit_op = secv_pkg::FUNIT_OP_SUB;
                    10'b0000000_111: dec_o.funit_op = secv_pkg::FUNIT_OP_AND;
                    10'b0000000_110: dec_o.funit_op = secv_pkg::FUNIT_OP_OR;
                    10'b0000000_100: dec_o.funit_op = secv_pkg::FUNIT_OP_XOR;
                    10'b0000000_010: dec_o.funit_op = secv_pkg::FUNIT_OP_SLT;
                    default:         dec_o.illegal  = 1'b1;
                endcase
            end
            // Only ADDI from the immediate group
            secv_pkg::OPC_OP_IMM: begin
                dec_o.funit    = secv_pkg::FUNIT_ALU;
                dec_o.rd_sel   = secv_pkg::RD_SEL_FUNIT;
                dec_o.src2_sel = secv_pkg::SRC2_SEL_IMM;
                dec_o.imm      = imm_i;
                dec_o.illegal  = (funct3 != 3'b000);
            end
            secv_pkg::OPC_LUI: begin
                dec_o.rd_sel = secv_pkg::RD_SEL_IMM;
                dec_o.imm    = imm_u;
            end
            // Word loads and stores only
            secv_pkg::OPC_LOAD: begin
                dec_o.funit    = secv_pkg::FUNIT_LSU;
                dec_o.funit_op = secv_pkg::FUNIT_OP_LOAD;
                dec_o.rd_sel   = secv_pkg::RD_SEL_FUNIT;
                dec_o.imm      = imm_i;
                dec_o.illegal  = (funct3 != 3'b010);
            end
            secv_pkg::OPC_STORE: begin
                dec_o.funit    = secv_pkg::FUNIT_LSU;
                dec_o.funit_op = secv_pkg::FUNIT_OP_STORE;
                dec_o.imm      = imm_s;
                dec_o.illegal  = (funct3 != 3'b010);
            end
            // BEQ and BNE
            secv_pkg::OPC_BRANCH: begin
                dec_o.pc_sel  = secv_pkg::PC_SEL_BRANCH;
                dec_o.bne     = funct3[0];
                dec_o.imm     = imm_b;
                dec_o.illegal = (funct3[2:1] != 2'b00);
            end
            secv_pkg::OPC_JAL: begin
                dec_o.rd_sel = secv_pkg::RD_SEL_NXTPC;
                dec_o.pc_sel = secv_pkg::PC_SEL_JUMP;
                dec_o.imm    = imm_j;
            end
            default: dec_o.illegal = 1'b1;
        endcase

        // Illegal encodings retire as a plain no-op
        if (dec_o.illegal) begin
            dec_o.funit  = secv_pkg::FUNIT_NONE;
            dec_o.rd_sel = secv_pkg::RD_SEL_NONE;
            dec_o.pc_sel = secv_pkg::PC_SEL_NXTPC;
        end
    end

endmodule

//--- secv_gpr.sv
// General purpose register file, two combinational reads, one write, x0 tied to zero
`timescale 1ns/100ps

module secv_gpr (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic [secv_pkg::REG_ADR_WIDTH-1:0] rs1_adr_i,
    input  logic [secv_pkg::REG_ADR_WIDTH-1:0] rs2_adr_i,
    input  logic [secv_pkg::REG_ADR_WIDTH-1:0] rd_adr_i,
    input  logic [secv_pkg::XLEN-1:0]          rd_dat_i,
    input  logic                               rd_wb_i,
    output logic [secv_pkg::XLEN-1:0]          rs1_dat_o,
    output logic [secv_pkg::XLEN-1:0]          rs2_dat_o
);

    logic [secv_pkg::XLEN-1:0] regs [secv_pkg::REG_COUNT];

    // Write port, x0 never written
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < secv_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wb_i && (rd_adr_i != '0)) begin
            regs[rd_adr_i] <= rd_dat_i;
        end
    end

    // Read ports
    assign rs1_dat_o = (rs1_adr_i == '0) ? '0 : regs[rs1_adr_i];
    assign rs2_dat_o = (rs2_adr_i == '0) ? '0 : regs[rs2_adr_i];

endmodule

//--- funit_if.sv
// Function-unit interface with control-side and unit-side modports
`timescale 1ns/100ps

interface funit_if;

    // Request, held stable while ena is high
    logic                      ena;
    secv_pkg::funit_op_t       op;
    logic [secv_pkg::XLEN-1:0] src1;
    logic [secv_pkg::XLEN-1:0] src2;
    // Store data
    logic [secv_pkg::XLEN-1:0] wdat;

    // Response, valid in the rdy cycle
    logic [secv_pkg::XLEN-1:0] res;
    logic                      rdy;
    logic                      err;

    // Core side
    modport ctrl (
        output ena, op, src1, src2, wdat,
        input  res, rdy, err
    );

    // Function unit side
    modport unit (
        input  ena, op, src1, src2, wdat,
        output res, rdy, err
    );

endinterface

//--- secv_pkg.sv
// Core widths, opcode and control enums, decoded-instruction struct
package secv_pkg;

    // Datapath and instruction widths
    localparam int XLEN = 32;
    localparam int ILEN = 32;

    // Word-address bits on the instruction and data bus
    localparam int IADR_WIDTH = 10;
    localparam int DADR_WIDTH = 10;

    // Register file geometry
    localparam int REG_COUNT     = 32;
    localparam int REG_ADR_WIDTH = $clog2(REG_COUNT);

    // ADDI x0,x0,0
    localparam logic [ILEN-1:0] INST_NOP = 32'h0000_0013;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    // Operations understood by the function units
    typedef enum logic [2:0] {
        FUNIT_OP_ADD,
        FUNIT_OP_SUB,
        FUNIT_OP_AND,
        FUNIT_OP_OR,
        FUNIT_OP_XOR,
        FUNIT_OP_SLT,
        FUNIT_OP_LOAD,
        FUNIT_OP_STORE
    } funit_op_t;

    typedef enum logic [1:0] {FUNIT_NONE, FUNIT_ALU, FUNIT_LSU} funit_t;
    typedef enum logic {SRC2_SEL_RS2, SRC2_SEL_IMM} src2_sel_t;
    typedef enum logic [1:0] {RD_SEL_NONE, RD_SEL_FUNIT, RD_SEL_IMM, RD_SEL_NXTPC} rd_sel_t;
    typedef enum logic [1:0] {PC_SEL_NXTPC, PC_SEL_BRANCH, PC_SEL_JUMP} pc_sel_t;

    // Main control states
    typedef enum logic [2:0] {
        STATE_IDLE,
        STATE_FETCH,
        STATE_DECODE,
        STATE_EXECUTE,
        STATE_WB
    } state_t;

    // Decoder output bundle
    typedef struct packed {
        logic [REG_ADR_WIDTH-1:0] rs1_adr;
        logic [REG_ADR_WIDTH-1:0] rs2_adr;
        logic [REG_ADR_WIDTH-1:0] rd_adr;
        funit_t                   funit;
        funit_op_t                funit_op;
        src2_sel_t                src2_sel;
        rd_sel_t                  rd_sel;
        pc_sel_t                  pc_sel;
        logic                     bne;
        logic [XLEN-1:0]          imm;
        logic                     illegal;
    } dec_t;

endpackage
